/* rtl/uce_pkg.sv */
`default_nettype none

package uce_pkg;

  // cache geometry
  localparam int paddr_width = 32;
  localparam int block_width = 64;
  localparam int sets = 8;
  localparam int assoc = 2;

  localparam int block_offset_width = $clog2(block_width / 8);
  localparam int index_width = $clog2(sets);
  localparam int way_width = $clog2(assoc);
  localparam int ptag_width = paddr_width - index_width - block_offset_width;

  // size field is log2 of the byte count
  localparam logic [1:0] block_size = 2'(block_offset_width);

  typedef enum logic [2:0] {
    e_miss_load,
    e_miss_store,
    e_uc_load,
    e_uc_store,
    e_clear
  } cache_req_type_e;

  typedef struct packed {
    cache_req_type_e          msg_type;
    logic [paddr_width-1:0]   addr;
    logic [1:0]               size;
    logic [block_width-1:0]   data;
  } cache_req_s;

  typedef struct packed {
    logic [way_width-1:0] repl_way;
    logic                 dirty;
  } cache_meta_s;

  typedef enum logic [1:0] {
    e_tag_set_clear,
    e_tag_set_tag,
    e_tag_read
  } tag_op_e;

  typedef struct packed {
    tag_op_e                 opcode;
    logic [index_width-1:0]  index;
    logic [way_width-1:0]    way;
    logic [ptag_width-1:0]   tag;
  } tag_pkt_s;

  typedef enum logic [1:0] {
    e_data_read,
    e_data_write,
    e_data_uncached
  } data_op_e;

  typedef struct packed {
    data_op_e                opcode;
    logic [index_width-1:0]  index;
    logic [way_width-1:0]    way;
    logic [block_width-1:0]  data;
  } data_pkt_s;

  typedef enum logic {
    e_stat_set_clear,
    e_stat_clear_dirty
  } stat_op_e;

  typedef struct packed {
    stat_op_e                opcode;
    logic [index_width-1:0]  index;
    logic [way_width-1:0]    way;
  } stat_pkt_s;

  typedef enum logic [1:0] {
    e_mem_rd,
    e_mem_wr,
    e_mem_uc_rd,
    e_mem_uc_wr
  } mem_op_e;

  typedef struct packed {
    mem_op_e                 msg_type;
    logic [paddr_width-1:0]  addr;
    logic [1:0]              size;
    logic [way_width-1:0]    way;
  } mem_hdr_s;

  typedef enum logic [3:0] {
    e_reset,
    e_clear_sweep,
    e_ready,
    e_send_critical,
    e_evict,
    e_evict_fill,
    e_writeback,
    e_fill,
    e_uc_read_wait
  } uce_state_e;

endpackage

`default_nettype wire

/* rtl/uce_req_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module uce_req_capture
  import uce_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        reset_i,
  input  wire cache_req_s  cache_req_i,
  input  wire logic        cache_req_v_i,
  input  wire cache_meta_s cache_meta_i,
  input  wire logic        cache_meta_v_i,
  input  wire logic        complete_i,
  output cache_req_s       req_o,
  output logic             req_v_o,
  output cache_meta_s      meta_o,
  output logic             meta_v_o
);

  // cache_req_v_i is the take strobe, valid and ready together
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      req_v_o  <= 1'b0;
      meta_v_o <= 1'b0;
    end
    else
    begin
      if (cache_req_v_i)
        req_v_o <= 1'b1;
      else if (complete_i)
        req_v_o <= 1'b0;

      if (cache_meta_v_i)
        meta_v_o <= 1'b1;
      else if (cache_req_v_i)
        meta_v_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cache_req_v_i)
      req_o <= cache_req_i;
    if (cache_meta_v_i)
      meta_o <= cache_meta_i;
  end

  // metadata always belongs to a request taken earlier
  assert property (@(posedge clk_i) disable iff (reset_i) cache_meta_v_i |-> req_v_o);

endmodule

`default_nettype wire

/* rtl/uce_victim_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module uce_victim_capture
  import uce_pkg::*;
(
  input  wire logic                   clk_i,
  input  wire logic                   reset_i,
  input  wire logic                   tag_read_i,
  input  wire logic                   data_read_i,
  input  wire logic [ptag_width-1:0]  tag_mem_i,
  input  wire logic [block_width-1:0] data_mem_i,
  output logic [ptag_width-1:0]       victim_tag_o,
  output logic [block_width-1:0]      victim_data_o,
  output logic                        victim_v_o
);

  logic tag_read_r;
  logic data_read_r;

  // the cache returns read data one cycle after the accept
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      tag_read_r  <= 1'b0;
      data_read_r <= 1'b0;
      victim_v_o  <= 1'b0;
    end
    else
    begin
      tag_read_r  <= tag_read_i;
      data_read_r <= data_read_i;
      if (tag_read_i | data_read_i)
        victim_v_o <= 1'b0;
      else if (tag_read_r & data_read_r)
        victim_v_o <= 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (tag_read_r)
      victim_tag_o <= tag_mem_i;
    if (data_read_r)
      victim_data_o <= data_mem_i;
  end

  // the evict step must see both yumis in the same cycle
  assert property (@(posedge clk_i) disable iff (reset_i) tag_read_i == data_read_i);

endmodule

`default_nettype wire

/* rtl/uce_credit_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module uce_credit_counter #(
  parameter int max_credits_p = 2
) (
  input  wire logic clk_i,
  input  wire logic reset_i,
  input  wire logic cmd_sent_i,
  input  wire logic resp_done_i,
  output logic      credits_full_o,
  output logic      credits_empty_o
);

  localparam int count_width = $clog2(max_credits_p + 1);

  logic [count_width-1:0] count_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      count_r <= '0;
    else if (cmd_sent_i & ~resp_done_i)
      count_r <= count_r + 1'b1;
    else if (resp_done_i & ~cmd_sent_i)
      count_r <= count_r - 1'b1;
  end

  assign credits_full_o  = (count_r == count_width'(max_credits_p));
  assign credits_empty_o = (count_r == '0);

  assert property (@(posedge clk_i) disable iff (reset_i)
    (credits_empty_o & resp_done_i) |-> cmd_sent_i);
  assert property (@(posedge clk_i) disable iff (reset_i)
    (credits_full_o & cmd_sent_i) |-> resp_done_i);

endmodule

`default_nettype wire

/* rtl/uce_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module uce_fsm
  import uce_pkg::*;
#(
  parameter int max_credits_p = 2
) (
  input  wire logic                   clk_i,
  input  wire logic                   reset_i,
  input  wire cache_req_s             cache_req_i,
  input  wire logic                   cache_req_v_i,
  input  wire cache_req_s             req_i,
  input  wire logic                   req_v_i,
  input  wire cache_meta_s            meta_i,
  input  wire logic                   meta_v_i,
  input  wire logic [ptag_width-1:0]  victim_tag_i,
  input  wire logic [block_width-1:0] victim_data_i,
  input  wire logic                   victim_v_i,
  input  wire logic                   credits_full_i,
  input  wire logic                   credits_empty_i,
  output tag_pkt_s                    tag_pkt_o,
  output logic                        tag_pkt_v_o,
  input  wire logic                   tag_pkt_yumi_i,
  output data_pkt_s                   data_pkt_o,
  output logic                        data_pkt_v_o,
  input  wire logic                   data_pkt_yumi_i,
  output stat_pkt_s                   stat_pkt_o,
  output logic                        stat_pkt_v_o,
  input  wire logic                   stat_pkt_yumi_i,
  output mem_hdr_s                    mem_cmd_hdr_o,
  output logic [block_width-1:0]      mem_cmd_data_o,
  output logic                        mem_cmd_v_o,
  input  wire logic                   mem_cmd_ready_i,
  input  wire mem_hdr_s               mem_resp_hdr_i,
  input  wire logic [block_width-1:0] mem_resp_data_i,
  input  wire logic                   mem_resp_v_i,
  output logic                        mem_resp_ready_o,
  output logic                        cache_req_ready_o,
  output logic                        cache_req_complete_o
);

  // every request issues at least one memory command
  if (max_credits_p < 1)
  begin : g_credit_check
    $error("max_credits_p must be at least 1");
  end

  uce_state_e state_r, state_n;
  logic [index_width-1:0] clear_idx_r;
  logic clear_up;
  logic load_resp_yumi;

  wire take = cache_req_v_i & cache_req_ready_o;
  wire cmd_done = mem_cmd_v_o & mem_cmd_ready_i;
  wire last_idx = (clear_idx_r == index_width'(sets - 1));
  wire miss_v = req_v_i & (req_i.msg_type inside {e_miss_load, e_miss_store});
  wire uc_load_v = req_v_i & (req_i.msg_type == e_uc_load);
  wire store_resp_v = mem_resp_v_i & (mem_resp_hdr_i.msg_type inside {e_mem_wr, e_mem_uc_wr});
  wire load_resp_v = mem_resp_v_i & (mem_resp_hdr_i.msg_type inside {e_mem_rd, e_mem_uc_rd});

  wire [index_width-1:0] req_idx = req_i.addr[block_offset_width +: index_width];
  wire [index_width-1:0] resp_idx = mem_resp_hdr_i.addr[block_offset_width +: index_width];
  wire [ptag_width-1:0] resp_tag =
    mem_resp_hdr_i.addr[block_offset_width + index_width +: ptag_width];

  // store acks are drained whatever the state
  assign mem_resp_ready_o = store_resp_v | load_resp_yumi;

  always_comb
  begin
    state_n = state_r;
    clear_up = 1'b0;
    load_resp_yumi = 1'b0;
    cache_req_ready_o = 1'b0;
    cache_req_complete_o = 1'b0;
    tag_pkt_o = '0;
    tag_pkt_v_o = 1'b0;
    data_pkt_o = '0;
    data_pkt_v_o = 1'b0;
    stat_pkt_o = '0;
    stat_pkt_v_o = 1'b0;
    mem_cmd_hdr_o = '0;
    mem_cmd_data_o = '0;
    mem_cmd_v_o = 1'b0;

    case (state_r)
      e_reset:
      begin
        if (credits_empty_i)
          state_n = e_clear_sweep;
      end
      e_clear_sweep:
      begin
        tag_pkt_o.opcode = e_tag_set_clear;
        tag_pkt_o.index = clear_idx_r;
        tag_pkt_v_o = 1'b1;
        stat_pkt_o.opcode = e_stat_set_clear;
        stat_pkt_o.index = clear_idx_r;
        stat_pkt_v_o = 1'b1;
        clear_up = tag_pkt_yumi_i & stat_pkt_yumi_i;
        cache_req_complete_o = clear_up & last_idx;
        if (cache_req_complete_o)
          state_n = e_ready;
      end
      e_ready:
      begin
        cache_req_ready_o = mem_cmd_ready_i & ~credits_full_i;
        if (take & (cache_req_i.msg_type == e_uc_store))
        begin
          mem_cmd_hdr_o.msg_type = e_mem_uc_wr;
          mem_cmd_hdr_o.addr = cache_req_i.addr;
          mem_cmd_hdr_o.size = cache_req_i.size;
          mem_cmd_data_o = cache_req_i.data;
          mem_cmd_v_o = 1'b1;
        end
        else if (take)
          state_n = (cache_req_i.msg_type == e_clear) ? e_clear_sweep : e_send_critical;
      end
      e_send_critical:
      begin
        if (miss_v)
        begin
          mem_cmd_hdr_o.msg_type = e_mem_rd;
          mem_cmd_hdr_o.addr = {req_i.addr[paddr_width-1:block_offset_width],
                                block_offset_width'(0)};
          mem_cmd_hdr_o.size = block_size;
          mem_cmd_hdr_o.way = meta_i.repl_way;
          mem_cmd_v_o = meta_v_i & mem_cmd_ready_i;
          if (cmd_done)
            state_n = meta_i.dirty ? e_evict : e_fill;
        end
        else if (uc_load_v)
        begin
          mem_cmd_hdr_o.msg_type = e_mem_uc_rd;
          mem_cmd_hdr_o.addr = req_i.addr;
          mem_cmd_hdr_o.size = req_i.size;
          mem_cmd_v_o = mem_cmd_ready_i;
          if (cmd_done)
            state_n = e_uc_read_wait;
        end
      end
      e_evict:
      begin
        data_pkt_o.opcode = e_data_read;
        data_pkt_o.index = req_idx;
        data_pkt_o.way = meta_i.repl_way;
        data_pkt_v_o = 1'b1;
        tag_pkt_o.opcode = e_tag_read;
        tag_pkt_o.index = req_idx;
        tag_pkt_o.way = meta_i.repl_way;
        tag_pkt_v_o = 1'b1;
        stat_pkt_o.opcode = e_stat_clear_dirty;
        stat_pkt_o.index = req_idx;
        stat_pkt_o.way = meta_i.repl_way;
        stat_pkt_v_o = 1'b1;
        if (data_pkt_yumi_i & tag_pkt_yumi_i & stat_pkt_yumi_i)
          state_n = e_evict_fill;
      end
      e_evict_fill, e_fill:
      begin
        tag_pkt_o.opcode = e_tag_set_tag;
        tag_pkt_o.index = resp_idx;
        tag_pkt_o.way = mem_resp_hdr_i.way;
        tag_pkt_o.tag = resp_tag;
        tag_pkt_v_o = load_resp_v;
        data_pkt_o.opcode = e_data_write;
        data_pkt_o.index = resp_idx;
        data_pkt_o.way = mem_resp_hdr_i.way;
        data_pkt_o.data = mem_resp_data_i;
        data_pkt_v_o = load_resp_v;
        load_resp_yumi = load_resp_v & tag_pkt_yumi_i & data_pkt_yumi_i;
        // a clean miss ends here, a dirty one still owes the writeback
        cache_req_complete_o = load_resp_yumi & (state_r == e_fill);
        if (load_resp_yumi)
          state_n = (state_r == e_fill) ? e_ready : e_writeback;
      end
      e_writeback:
      begin
        mem_cmd_hdr_o.msg_type = e_mem_wr;
        mem_cmd_hdr_o.addr = {victim_tag_i, req_idx, block_offset_width'(0)};
        mem_cmd_hdr_o.size = block_size;
        mem_cmd_data_o = victim_data_i;
        mem_cmd_v_o = victim_v_i & mem_cmd_ready_i;
        cache_req_complete_o = cmd_done;
        if (cmd_done)
          state_n = e_ready;
      end
      e_uc_read_wait:
      begin
        data_pkt_o.opcode = e_data_uncached;
        data_pkt_o.data = mem_resp_data_i;
        data_pkt_v_o = load_resp_v;
        load_resp_yumi = load_resp_v & data_pkt_yumi_i;
        cache_req_complete_o = load_resp_yumi;
        if (load_resp_yumi)
          state_n = e_ready;
      end
      default:
        state_n = e_reset;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_reset;
      clear_idx_r <= '0;
    end
    else
    begin
      state_r <= state_n;
      if (clear_up)
        clear_idx_r <= last_idx ? '0 : clear_idx_r + 1'b1;
    end
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
    state_r inside {e_reset, e_clear_sweep, e_ready, e_send_critical, e_evict,
                    e_evict_fill, e_writeback, e_fill, e_uc_read_wait});

endmodule

`default_nettype wire

/* rtl/uce_top.sv */
`timescale 1ns/1ps
`default_nettype none

module uce_top
  import uce_pkg::*;
#(
  parameter int max_credits_p = 2
) (
  input  wire logic                   clk_i,
  input  wire logic                   reset_i,
  input  wire cache_req_s             cache_req_i,
  input  wire logic                   cache_req_v_i,
  output logic                        cache_req_ready_o,
  input  wire cache_meta_s            cache_meta_i,
  input  wire logic                   cache_meta_v_i,
  output logic                        cache_req_complete_o,
  output tag_pkt_s                    tag_pkt_o,
  output logic                        tag_pkt_v_o,
  input  wire logic                   tag_pkt_yumi_i,
  input  wire logic [ptag_width-1:0]  tag_mem_i,
  output data_pkt_s                   data_pkt_o,
  output logic                        data_pkt_v_o,
  input  wire logic                   data_pkt_yumi_i,
  input  wire logic [block_width-1:0] data_mem_i,
  output stat_pkt_s                   stat_pkt_o,
  output logic                        stat_pkt_v_o,
  input  wire logic                   stat_pkt_yumi_i,
  output logic                        credits_full_o,
  output logic                        credits_empty_o,
  output mem_hdr_s                    mem_cmd_hdr_o,
  output logic [block_width-1:0]      mem_cmd_data_o,
  output logic                        mem_cmd_v_o,
  input  wire logic                   mem_cmd_ready_i,
  input  wire mem_hdr_s               mem_resp_hdr_i,
  input  wire logic [block_width-1:0] mem_resp_data_i,
  input  wire logic                   mem_resp_v_i,
  output logic                        mem_resp_ready_o
);

  cache_req_s req;
  cache_meta_s meta;
  logic req_v;
  logic meta_v;
  logic [ptag_width-1:0] victim_tag;
  logic [block_width-1:0] victim_data;
  logic victim_v;

  wire req_taken = cache_req_v_i & cache_req_ready_o;
  wire tag_read = tag_pkt_v_o & tag_pkt_yumi_i & (tag_pkt_o.opcode == e_tag_read);
  wire data_read = data_pkt_v_o & data_pkt_yumi_i & (data_pkt_o.opcode == e_data_read);
  wire cmd_sent = mem_cmd_v_o & mem_cmd_ready_i;
  wire resp_done = mem_resp_v_i & mem_resp_ready_o;

  uce_req_capture i_req_capture (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .cache_req_i    (cache_req_i),
    .cache_req_v_i  (req_taken),
    .cache_meta_i   (cache_meta_i),
    .cache_meta_v_i (cache_meta_v_i),
    .complete_i     (cache_req_complete_o),
    .req_o          (req),
    .req_v_o        (req_v),
    .meta_o         (meta),
    .meta_v_o       (meta_v)
  );

  uce_victim_capture i_victim_capture (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .tag_read_i    (tag_read),
    .data_read_i   (data_read),
    .tag_mem_i     (tag_mem_i),
    .data_mem_i    (data_mem_i),
    .victim_tag_o  (victim_tag),
    .victim_data_o (victim_data),
    .victim_v_o    (victim_v)
  );

  uce_credit_counter #(
    .max_credits_p (max_credits_p)
  ) i_credit_counter (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .cmd_sent_i      (cmd_sent),
    .resp_done_i     (resp_done),
    .credits_full_o  (credits_full_o),
    .credits_empty_o (credits_empty_o)
  );

  uce_fsm #(
    .max_credits_p (max_credits_p)
  ) i_fsm (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .cache_req_i          (cache_req_i),
    .cache_req_v_i        (cache_req_v_i),
    .req_i                (req),
    .req_v_i              (req_v),
    .meta_i               (meta),
    .meta_v_i             (meta_v),
    .victim_tag_i         (victim_tag),
    .victim_data_i        (victim_data),
    .victim_v_i           (victim_v),
    .credits_full_i       (credits_full_o),
    .credits_empty_i      (credits_empty_o),
    .tag_pkt_o            (tag_pkt_o),
    .tag_pkt_v_o          (tag_pkt_v_o),
    .tag_pkt_yumi_i       (tag_pkt_yumi_i),
    .data_pkt_o           (data_pkt_o),
    .data_pkt_v_o         (data_pkt_v_o),
    .data_pkt_yumi_i      (data_pkt_yumi_i),
    .stat_pkt_o           (stat_pkt_o),
    .stat_pkt_v_o         (stat_pkt_v_o),
    .stat_pkt_yumi_i      (stat_pkt_yumi_i),
    .mem_cmd_hdr_o        (mem_cmd_hdr_o),
    .mem_cmd_data_o       (mem_cmd_data_o),
    .mem_cmd_v_o          (mem_cmd_v_o),
    .mem_cmd_ready_i      (mem_cmd_ready_i),
    .mem_resp_hdr_i       (mem_resp_hdr_i),
    .mem_resp_data_i      (mem_resp_data_i),
    .mem_resp_v_i         (mem_resp_v_i),
    .mem_resp_ready_o     (mem_resp_ready_o),
    .cache_req_ready_o    (cache_req_ready_o),
    .cache_req_complete_o (cache_req_complete_o)
  );

endmodule

`default_nettype wire

/* verification/uce_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module uce_tb
  import uce_pkg::*;
();

  localparam int max_credits = 2;
  localparam int reset_cycles = 10;
  localparam int test_count = 6;
  localparam int cycles_per_test = 3000;
  localparam int watchdog_cycles = test_count * cycles_per_test + 2000;

  typedef struct packed {
    mem_hdr_s               hdr;
    logic [block_width-1:0] data;
  } mem_resp_s;

  logic clk_i = 1'b0;
  logic reset_i = 1'b1;
  cache_req_s cache_req_i = '0;
  logic cache_req_v_i = 1'b0;
  logic cache_req_ready_o;
  cache_meta_s cache_meta_i = '0;
  logic cache_meta_v_i = 1'b0;
  logic cache_req_complete_o;
  tag_pkt_s tag_pkt_o;
  logic tag_pkt_v_o;
  logic tag_pkt_yumi_i = 1'b0;
  logic [ptag_width-1:0] tag_mem_i = '0;
  data_pkt_s data_pkt_o;
  logic data_pkt_v_o;
  logic data_pkt_yumi_i = 1'b0;
  logic [block_width-1:0] data_mem_i = '0;
  stat_pkt_s stat_pkt_o;
  logic stat_pkt_v_o;
  logic stat_pkt_yumi_i = 1'b0;
  logic credits_full_o;
  logic credits_empty_o;
  mem_hdr_s mem_cmd_hdr_o;
  logic [block_width-1:0] mem_cmd_data_o;
  logic mem_cmd_v_o;
  logic mem_cmd_ready_i = 1'b0;
  mem_hdr_s mem_resp_hdr_i = '0;
  logic [block_width-1:0] mem_resp_data_i = '0;
  logic mem_resp_v_i = 1'b0;
  logic mem_resp_ready_o;

  integer seed = 32'h92cf;

  // cache model
  logic [ptag_width-1:0] tag_array [sets][assoc];
  logic [block_width-1:0] data_array [sets][assoc];
  logic dirty_array [sets][assoc];
  logic [ptag_width-1:0] tag_read_q = '0;
  logic [block_width-1:0] data_read_q = '0;

  // memory model
  logic [block_width-1:0] mem_array [logic [paddr_width-1:0]];
  mem_resp_s resp_q [$];
  logic hold_resp = 1'b0;
  logic resp_taken = 1'b0;

  logic reset_seen = 1'b0;
  logic clear_done = 1'b0;
  int clear_idx = 0;
  int store_acks = 0;

  uce_top #(
    .max_credits_p (max_credits)
  ) i_dut (.*);

  always #5 clk_i = ~clk_i;

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string test, input logic [127:0] expected,
                             input logic [127:0] actual);
    assert (actual === expected)
    else
      fail_run($sformatf("FAIL %s expected %0h actual %0h", test, expected, actual));
  endtask

  function automatic logic [paddr_width-1:0] block_addr(input logic [paddr_width-1:0] addr);
    return {addr[paddr_width-1:block_offset_width], block_offset_width'(0)};
  endfunction

  function automatic logic [block_width-1:0] mem_value(input logic [paddr_width-1:0] addr);
    logic [paddr_width-1:0] blk;
    blk = block_addr(addr);
    if (mem_array.exists(blk))
      return mem_array[blk];
    // unwritten blocks read back a pattern of their full address
    return {blk ^ 32'hc3a5_5a3c, ~blk};
  endfunction

  task automatic watch_clear_sweep();
    logic tag_acc;
    logic stat_acc;
    tag_acc = tag_pkt_v_o && tag_pkt_yumi_i;
    stat_acc = stat_pkt_v_o && stat_pkt_yumi_i;
    if (!clear_done)
    begin
      check_value("clear ready low", 0, cache_req_ready_o);
      if (tag_acc)
      begin
        check_value("clear tag opcode", e_tag_set_clear, tag_pkt_o.opcode);
        check_value("clear tag index", clear_idx, tag_pkt_o.index);
      end
      if (stat_acc)
      begin
        check_value("clear stat opcode", e_stat_set_clear, stat_pkt_o.opcode);
        check_value("clear stat index", clear_idx, stat_pkt_o.index);
      end
      // a set is done only once both of its packets are taken
      if (tag_acc && stat_acc)
        clear_idx++;
      if (cache_req_complete_o)
      begin
        check_value("clear index count", sets, clear_idx);
        clear_done = 1'b1;
      end
    end
  endtask

  task automatic update_cache();
    tag_pkt_s t;
    data_pkt_s d;
    stat_pkt_s s;
    t = tag_pkt_o;
    d = data_pkt_o;
    s = stat_pkt_o;
    if (tag_pkt_v_o && tag_pkt_yumi_i)
    begin
      case (t.opcode)
        e_tag_set_clear:
        begin
          for (int w = 0; w < assoc; w++)
            tag_array[t.index][w] = '0;
        end
        e_tag_set_tag:
          tag_array[t.index][t.way] = t.tag;
        default:
          tag_read_q = tag_array[t.index][t.way];
      endcase
    end
    if (data_pkt_v_o && data_pkt_yumi_i)
    begin
      if (d.opcode == e_data_write)
        data_array[d.index][d.way] = d.data;
      else if (d.opcode == e_data_read)
        data_read_q = data_array[d.index][d.way];
    end
    if (stat_pkt_v_o && stat_pkt_yumi_i)
    begin
      if (s.opcode == e_stat_set_clear)
      begin
        for (int w = 0; w < assoc; w++)
          dirty_array[s.index][w] = 1'b0;
      end
      else
        dirty_array[s.index][s.way] = 1'b0;
    end
  endtask

  task automatic update_memory();
    mem_resp_s resp;
    if (mem_resp_v_i && mem_resp_ready_o)
    begin
      void'(resp_q.pop_front());
      resp_taken = 1'b1;
      if (mem_resp_hdr_i.msg_type inside {e_mem_wr, e_mem_uc_wr})
        store_acks++;
    end
    if (mem_cmd_v_o && mem_cmd_ready_i)
    begin
      resp.hdr = mem_cmd_hdr_o;
      resp.data = '0;
      if (mem_cmd_hdr_o.msg_type inside {e_mem_wr, e_mem_uc_wr})
        mem_array[block_addr(mem_cmd_hdr_o.addr)] = mem_cmd_data_o;
      else
        resp.data = mem_value(mem_cmd_hdr_o.addr);
      resp_q.push_back(resp);
    end
  endtask

  task automatic drive_inputs();
    logic yumi;
    // tag and data share one accept so victim reads stay paired
    yumi = ($random(seed) & 3) != 0;
    tag_pkt_yumi_i = yumi;
    data_pkt_yumi_i = yumi;
    stat_pkt_yumi_i = ($random(seed) & 3) != 0;
    tag_mem_i = tag_read_q;
    data_mem_i = data_read_q;
    // with responses held only the credit count can stop a command
    mem_cmd_ready_i = hold_resp || (resp_q.size() < max_credits);
    if (resp_taken)
    begin
      mem_resp_v_i = 1'b0;
      resp_taken = 1'b0;
    end
    if (!mem_resp_v_i && resp_q.size() > 0 && !hold_resp && ($random(seed) & 1))
    begin
      mem_resp_v_i = 1'b1;
      mem_resp_hdr_i = resp_q[0].hdr;
      mem_resp_data_i = resp_q[0].data;
    end
  endtask

  // models update on the rising edge and drive on the falling edge
  always
  begin : models
    @(posedge clk_i);
    if (reset_i)
    begin
      if (reset_seen)
      begin
        check_value("reset valids", 0, {tag_pkt_v_o, data_pkt_v_o, stat_pkt_v_o, mem_cmd_v_o});
        check_value("reset handshakes", 0,
                    {cache_req_ready_o, cache_req_complete_o, mem_resp_ready_o});
        check_value("reset credits empty", 1, credits_empty_o);
      end
      reset_seen = 1'b1;
    end
    else
    begin
      watch_clear_sweep();
      update_cache();
      update_memory();
    end
    @(negedge clk_i);
    drive_inputs();
  end

  task automatic take_request(input cache_req_s req, output logic cmd_v, output mem_hdr_s hdr,
                              output logic [block_width-1:0] data);
    @(negedge clk_i);
    cache_req_i = req;
    cache_req_v_i = 1'b1;
    @(posedge clk_i);
    while (!cache_req_ready_o)
      @(posedge clk_i);
    cmd_v = mem_cmd_v_o && mem_cmd_ready_i;
    hdr = mem_cmd_hdr_o;
    data = mem_cmd_data_o;
    @(negedge clk_i);
    cache_req_v_i = 1'b0;
  endtask

  task automatic wait_command(output mem_hdr_s hdr, output logic [block_width-1:0] data,
                              output logic complete);
    @(posedge clk_i);
    while (!(mem_cmd_v_o && mem_cmd_ready_i))
      @(posedge clk_i);
    hdr = mem_cmd_hdr_o;
    data = mem_cmd_data_o;
    complete = cache_req_complete_o;
  endtask

  task automatic wait_tag_accept(output tag_pkt_s t, output data_pkt_s d, output stat_pkt_s s);
    @(posedge clk_i);
    while (!(tag_pkt_v_o && tag_pkt_yumi_i))
      @(posedge clk_i);
    t = tag_pkt_o;
    d = data_pkt_o;
    s = stat_pkt_o;
  endtask

  task automatic wait_data_accept(output data_pkt_s d, output logic complete);
    @(posedge clk_i);
    while (!(data_pkt_v_o && data_pkt_yumi_i))
      @(posedge clk_i);
    d = data_pkt_o;
    complete = cache_req_complete_o;
  endtask

  task automatic wait_complete();
    @(posedge clk_i);
    while (!cache_req_complete_o)
      @(posedge clk_i);
  endtask

  task automatic run_uc_store(input string test, input logic [paddr_width-1:0] addr,
                              input logic [block_width-1:0] data);
    cache_req_s req;
    logic cmd_v;
    mem_hdr_s hdr;
    logic [block_width-1:0] cmd_data;
    req.msg_type = e_uc_store;
    req.addr = addr;
    req.size = block_size;
    req.data = data;
    take_request(req, cmd_v, hdr, cmd_data);
    check_value({test, " cmd valid"}, 1, cmd_v);
    check_value({test, " cmd type"}, e_mem_uc_wr, hdr.msg_type);
    check_value({test, " cmd addr"}, addr, hdr.addr);
    check_value({test, " cmd data"}, data, cmd_data);
  endtask

  task automatic run_uc_load(input logic [paddr_width-1:0] addr,
                             input logic [block_width-1:0] value);
    cache_req_s req;
    logic cmd_v;
    logic complete;
    mem_hdr_s hdr;
    data_pkt_s d;
    logic [block_width-1:0] cmd_data;
    mem_array[block_addr(addr)] = value;
    req.msg_type = e_uc_load;
    req.addr = addr;
    req.size = block_size;
    req.data = '0;
    take_request(req, cmd_v, hdr, cmd_data);
    wait_command(hdr, cmd_data, complete);
    check_value("uc_load cmd type", e_mem_uc_rd, hdr.msg_type);
    check_value("uc_load cmd addr", addr, hdr.addr);
    wait_data_accept(d, complete);
    check_value("uc_load pkt opcode", e_data_uncached, d.opcode);
    check_value("uc_load pkt data", value, d.data);
    check_value("uc_load complete", 1, complete);
  endtask

  task automatic run_miss(input string test, input logic [paddr_width-1:0] addr,
                          input logic [way_width-1:0] way, input logic dirty,
                          input logic [block_width-1:0] fill);
    cache_req_s req;
    logic cmd_v;
    logic complete;
    mem_hdr_s hdr;
    tag_pkt_s t;
    data_pkt_s d;
    stat_pkt_s s;
    logic [block_width-1:0] cmd_data;
    logic [index_width-1:0] idx;
    logic [ptag_width-1:0] tag;
    logic [ptag_width-1:0] old_tag;
    logic [block_width-1:0] old_data;
    idx = addr[block_offset_width +: index_width];
    tag = addr[paddr_width-1 -: ptag_width];
    old_tag = tag_array[idx][way];
    old_data = data_array[idx][way];
    dirty_array[idx][way] = dirty;
    mem_array[block_addr(addr)] = fill;
    req.msg_type = e_miss_load;
    req.addr = addr;
    req.size = block_size;
    req.data = '0;
    take_request(req, cmd_v, hdr, cmd_data);
    cache_meta_i.repl_way = way;
    cache_meta_i.dirty = dirty;
    cache_meta_v_i = 1'b1;
    @(negedge clk_i);
    cache_meta_v_i = 1'b0;
    wait_command(hdr, cmd_data, complete);
    check_value({test, " rd type"}, e_mem_rd, hdr.msg_type);
    check_value({test, " rd addr"}, block_addr(addr), hdr.addr);
    check_value({test, " rd way"}, way, hdr.way);
    if (dirty)
    begin
      wait_tag_accept(t, d, s);
      check_value({test, " evict tag"}, {e_tag_read, idx, way}, {t.opcode, t.index, t.way});
      check_value({test, " evict data"}, {e_data_read, idx, way}, {d.opcode, d.index, d.way});
      check_value({test, " evict stat"}, {e_stat_clear_dirty, idx, way},
                  {s.opcode, s.index, s.way});
      wait_command(hdr, cmd_data, complete);
      check_value({test, " wr type"}, e_mem_wr, hdr.msg_type);
      check_value({test, " wr addr"}, {old_tag, idx, block_offset_width'(0)}, hdr.addr);
      check_value({test, " wr data"}, old_data, cmd_data);
      check_value({test, " wr complete"}, 1, complete);
    end
    else
      wait_complete();
    @(negedge clk_i);
    check_value({test, " fill tag"}, tag, tag_array[idx][way]);
    check_value({test, " fill data"}, fill, data_array[idx][way]);
    if (dirty)
      check_value({test, " dirty bit"}, 0, dirty_array[idx][way]);
  endtask

  task automatic run_credit_limit(input logic [block_width-1:0] data_a,
                                  input logic [block_width-1:0] data_b);
    while (!credits_empty_o)
      @(negedge clk_i);
    hold_resp = 1'b1;
    run_uc_store("credit store a", 32'h0000_3000, data_a);
    run_uc_store("credit store b", 32'h0000_3008, data_b);
    @(posedge clk_i);
    check_value("credits full raised", 1, credits_full_o);
    check_value("credits ready low", 0, cache_req_ready_o);
    hold_resp = 1'b0;
    while (!credits_empty_o)
      @(posedge clk_i);
    check_value("credits full cleared", 0, credits_full_o);
    check_value("credits ready back", 1, cache_req_ready_o);
  endtask

  initial
  begin : watchdog
    repeat (watchdog_cycles) @(posedge clk_i);
    fail_run("timeout: the tests did not finish within the cycle limit");
  end

  initial
  begin : stimulus
    logic [block_width-1:0] rnd [6];
    int acks;
    for (int i = 0; i < 6; i++)
      rnd[i] = {$random(seed), $random(seed)};
    // stale contents so the sweep has something to clear
    for (int s = 0; s < sets; s++)
    begin
      for (int w = 0; w < assoc; w++)
      begin
        tag_array[s][w] = ptag_width'($random(seed)) | 1'b1;
        data_array[s][w] = {$random(seed), $random(seed)};
        dirty_array[s][w] = 1'b1;
      end
    end
    repeat (reset_cycles) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    while (!clear_done)
      @(negedge clk_i);
    for (int s = 0; s < sets; s++)
    begin
      for (int w = 0; w < assoc; w++)
      begin
        check_value("clear tag", 0, tag_array[s][w]);
        check_value("clear dirty", 0, dirty_array[s][w]);
      end
    end

    acks = store_acks;
    run_uc_store("uc_store", 32'h0000_1238, rnd[0]);
    while (store_acks == acks)
      @(negedge clk_i);
    @(posedge clk_i);
    check_value("uc_store credits empty", 1, credits_empty_o);

    run_uc_load(32'h0000_2450, rnd[1]);
    run_miss("clean miss", 32'h0001_3a58, 1'b1, 1'b0, rnd[2]);
    // same set and way, so the clean fill above becomes the victim
    run_miss("dirty miss", 32'h0007_7c5c, 1'b1, 1'b1, rnd[3]);
    run_credit_limit(rnd[4], rnd[5]);

    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
rtl/uce_pkg.sv
rtl/uce_req_capture.sv
rtl/uce_victim_capture.sv
rtl/uce_credit_counter.sv
rtl/uce_fsm.sv
rtl/uce_top.sv
verification/uce_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the uce testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module uce_tb \
  -f vlog.f --Mdir obj_dir -o uce_tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "compile failed, see build.log"
  exit 1
fi

./obj_dir/uce_tb_sim > sim.log 2>&1
sim_status=$?
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status, see sim.log"
  exit 1
fi

if grep -q "^Testbench passed$" sim.log; then
  echo "PASS"
  exit 0
fi

echo "FAIL: pass message not found in sim.log"
exit 1
